// File: sim.f
+incdir+include
design/pmaPkg.sv
design/baseRegisters.sv
design/sweepCounter.sv
design/cycleSequencer.sv
design/addressMux.sv
design/pmaTop.sv
bench/pma_assert.sv
bench/pmaTb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pmaTb -f sim.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VpmaTb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: bench/pmaTb.sv
`timescale 1ns/1ps
`include "pma_consts.svh"

module pmaTb;

  import pmaPkg::*;

  localparam int chReq = 0;
  localparam int chWb = 1;
  localparam int chBoth = 2;
  localparam int bpNone = 0;
  localparam int bpRandom = 1;
  localparam int bpHold = 2;

  logic                 clock;
  logic                 rstN;
  logic                 reqValid;
  logic                 reqReady;
  reqOpE                reqOp;
  logic [`PA_WIDTH-1:0] reqAddr;
  logic                 reqUser;
  logic                 reqPaged;
  logic                 wbValid;
  logic                 wbReady;
  logic [`PA_WIDTH-1:0] wbAddr;
  logic                 paValid;
  logic                 paReady;
  logic [`PA_WIDTH-1:0] pa;
  logic                 paPar;
  cycleE                paCycle;

  // stimulus table with one entry per index.
  string                tName[$];
  int                   tChan[$];
  reqOpE                tOp[$];
  logic [`PA_WIDTH-1:0] tAddr[$];
  logic                 tUser[$];
  logic                 tPaged[$];
  int                   tCount[$];
  int                   tBp[$];

  logic [`PA_WIDTH-1:0]   expAddr[$];
  cycleE                  expCycle[$];
  logic [`PAGE_WIDTH-1:0] modelUbr;
  logic [`PAGE_WIDTH-1:0] modelEbr;
  logic [`PA_WIDTH-1:0]   modelEra;
  logic [`PA_WIDTH-1:0]   heldPa;
  string                  curName;
  int                     errorCount;
  int                     popCount;
  int                     cycle;
  int                     bpMode;
  int                     holdUntil;
  int                     sweepPops;
  logic                   latencyDue;
  logic                   stallPrev;
  logic                   sweepActive;

  pmaTop i_dut (
    .clock(clock), .rstN(rstN),
    .reqValid(reqValid), .reqReady(reqReady), .reqOp(reqOp), .reqAddr(reqAddr),
    .reqUser(reqUser), .reqPaged(reqPaged),
    .wbValid(wbValid), .wbReady(wbReady), .wbAddr(wbAddr),
    .paValid(paValid), .paReady(paReady), .pa(pa), .paPar(paPar), .paCycle(paCycle)
  );

  bind pmaTop pmaAssert u_pmaAssert (
    .clock(clock), .rstN(rstN), .reqReady(reqReady), .wbReady(wbReady),
    .paValid(paValid), .paReady(paReady), .pa(pa), .issue(issue),
    .ubrLoad(ubrLoad), .ebrLoad(ebrLoad), .sweepLoad(sweepLoad), .state(i_seq.state)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic checkValue(string testName, string what, logic [31:0] expected,
                            logic [31:0] actual);
    if (expected !== actual) begin
      errorCount++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
    end
  endtask

  task automatic addEntry(string name, int chan, reqOpE op, logic [`PA_WIDTH-1:0] addr,
                          logic user, logic paged, int count, int bp);
    tName.push_back(name);
    tChan.push_back(chan);
    tOp.push_back(op);
    tAddr.push_back(addr);
    tUser.push_back(user);
    tPaged.push_back(paged);
    tCount.push_back(count);
    tBp.push_back(bp);
  endtask

  // a combined entry puts the inverted address on the writeback channel.
  function automatic logic [`PA_WIDTH-1:0] writebackAddr(int i);
    return (tChan[i] == chBoth) ? ~tAddr[i] : tAddr[i];
  endfunction

  task automatic pushExpected(logic [`PA_WIDTH-1:0] addr, cycleE cyc);
    expAddr.push_back(addr);
    expCycle.push_back(cyc);
    if (cyc != cycEra) begin
      modelEra = addr;
    end
  endtask

  // writebacks come out before a read that is presented with them.
  task automatic predict(int i);
    logic [`PAGE_WIDTH-1:0] page;
    page = tAddr[i][`PA_WIDTH-1 -: `PAGE_WIDTH];
    if (tChan[i] != chReq) begin
      pushExpected(writebackAddr(i), cycWriteback);
    end
    if (tChan[i] != chWb) begin
      case (tOp[i])
        opRead: begin
          if (tPaged[i]) begin
            pushExpected({tUser[i] ? modelUbr : modelEbr, tAddr[i][`LINE_WIDTH-1:0]}, cycEbox);
          end else begin
            pushExpected(tAddr[i], cycEbox);
          end
        end
        opReadEra: pushExpected(modelEra, cycEra);
        opLoadUbr: modelUbr = page;
        opLoadEbr: modelEbr = page;
        opSweep: begin
          for (int k = `SWEEP_LAST; k >= 0; k--) begin
            pushExpected({page, `LINE_WIDTH'(k)}, cycSweep);
          end
        end
        default: ;
      endcase
    end
  endtask

  task automatic applyEntry(int i);
    int startPops;
    bit reqDone;
    bit wbDone;
    curName <= tName[i];
    bpMode <= tBp[i];
    if (tBp[i] == bpHold) begin
      holdUntil <= cycle + 12;
    end
    startPops = popCount;
    predict(i);
    reqDone = (tChan[i] == chWb);
    wbDone = (tChan[i] == chReq);
    @(posedge clock);
    if (!reqDone) begin
      reqValid <= 1'b1;
      reqOp <= tOp[i];
      reqAddr <= tAddr[i];
      reqUser <= tUser[i];
      reqPaged <= tPaged[i];
    end
    if (!wbDone) begin
      wbValid <= 1'b1;
      wbAddr <= writebackAddr(i);
    end
    while (!(reqDone && wbDone)) begin
      @(posedge clock);
      if (wbValid && wbReady) begin
        wbValid <= 1'b0;
        wbDone = 1'b1;
      end
      if (reqValid && reqReady) begin
        reqValid <= 1'b0;
        reqDone = 1'b1;
      end
    end
    while (popCount - startPops < tCount[i]) begin
      @(posedge clock);
    end
    bpMode <= bpNone;
    repeat (2) @(posedge clock);
    checkValue(tName[i], "address count", 32'(tCount[i]), 32'(popCount - startPops));
  endtask

  task automatic runWatchdog(int limitCycles);
    repeat (limitCycles) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles", limitCycles);
    $display("Test failures found");
    $finish;
  endtask

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle < holdUntil) begin
      paReady <= 1'b0;
    end else if (bpMode == bpRandom) begin
      paReady <= ($urandom_range(3) != 0);
    end else begin
      paReady <= 1'b1;
    end
  end

  // output monitor with the latency, stall and sweep checks.
  always @(posedge clock) begin
    if (rstN) begin
      if (latencyDue) begin
        checkValue(curName, "paValid one cycle after accept", 32'd1, 32'(paValid));
      end
      if (stallPrev) begin
        checkValue(curName, "held paValid", 32'd1, 32'(paValid));
        checkValue(curName, "held pa", 32'(heldPa), 32'(pa));
      end
      if (paValid && !paReady && ((reqValid && reqReady) || (wbValid && wbReady))) begin
        errorCount++;
        $display("Test %s accepted a request while the output was blocked", curName);
      end
      if (sweepActive && sweepPops < `SWEEP_LAST) begin
        checkValue(curName, "reqReady during sweep", 32'd0, 32'(reqReady));
      end
      if (paValid && paReady) begin
        if (expAddr.size() == 0) begin
          errorCount++;
          $display("Test %s put out an address that no request asked for", curName);
        end else begin
          checkValue(curName, "pa", 32'(expAddr.pop_front()), 32'(pa));
          checkValue(curName, "paCycle", 32'(expCycle.pop_front()), 32'(paCycle));
        end
        checkValue(curName, "odd parity", 32'd1, 32'(^{pa, paPar}));
        if (paCycle == cycSweep) begin
          sweepPops++;
          sweepActive = sweepActive && (sweepPops <= `SWEEP_LAST);
        end
        popCount++;
      end
      latencyDue = (wbValid && wbReady) ||
                   (reqValid && reqReady && (reqOp == opRead || reqOp == opReadEra));
      stallPrev = paValid && !paReady;
      heldPa = pa;
      if (reqValid && reqReady && reqOp == opSweep) begin
        sweepActive = 1'b1;
        sweepPops = 0;
      end
    end
  end

  initial begin
    void'($urandom(2264));
    rstN = 1'b0;
    reqValid = 1'b0;
    reqOp = opRead;
    reqAddr = '0;
    reqUser = 1'b0;
    reqPaged = 1'b0;
    wbValid = 1'b0;
    wbAddr = '0;
    paReady = 1'b1;
    {modelUbr, modelEbr, modelEra, heldPa} = '0;
    {errorCount, popCount, cycle, bpMode, holdUntil, sweepPops} = '0;
    {latencyDue, stallPrev, sweepActive} = '0;
    curName = "reset";
    addEntry("readPlain", chReq, opRead, 22'h012345, 1'b0, 1'b0, 1, bpNone);
    addEntry("pagedNoBase", chReq, opRead, 22'h2C01F5, 1'b1, 1'b1, 1, bpNone);
    addEntry("loadUbr", chReq, opLoadUbr, 22'h2A5600, 1'b0, 1'b0, 0, bpNone);
    addEntry("loadEbr", chReq, opLoadEbr, 22'h155A00, 1'b0, 1'b0, 0, bpNone);
    addEntry("pagedUser", chReq, opRead, 22'h3FF0A3, 1'b1, 1'b1, 1, bpNone);
    addEntry("pagedExec", chReq, opRead, 22'h0000C7, 1'b0, 1'b1, 1, bpNone);
    addEntry("eraRead", chReq, opReadEra, 22'h000000, 1'b0, 1'b0, 1, bpNone);
    addEntry("eraTwice", chReq, opReadEra, 22'h000000, 1'b0, 1'b0, 1, bpNone);
    addEntry("sweep", chReq, opSweep, 22'h1B3E55, 1'b0, 1'b0, 8, bpRandom);
    addEntry("eraSweep", chReq, opReadEra, 22'h000000, 1'b0, 1'b0, 1, bpNone);
    addEntry("wbPriority", chBoth, opRead, 22'h0ABCDE, 1'b0, 1'b0, 2, bpNone);
    addEntry("wbOnly", chWb, opRead, 22'h2468AC, 1'b0, 1'b0, 1, bpNone);
    addEntry("eraWb", chReq, opReadEra, 22'h000000, 1'b0, 1'b0, 1, bpNone);
    addEntry("stallHold", chBoth, opRead, 22'h13579B, 1'b0, 1'b0, 2, bpHold);
    addEntry("readAfterStall", chReq, opRead, 22'h0F0F0F, 1'b0, 1'b0, 1, bpNone);
    fork
      runWatchdog(tName.size() * 40 + 8);
    join_none
    repeat (8) @(posedge clock);
    rstN <= 1'b1;
    @(posedge clock);
    checkValue("reset", "paValid", 32'd0, 32'(paValid));
    for (int i = 0; i < tName.size(); i++) begin
      applyEntry(i);
    end
    checkValue("end", "addresses still expected", 32'd0, 32'(expAddr.size()));
    $display("Check failures: %0d, assertion failures: %0d", errorCount,
             i_dut.u_pmaAssert.failCount);
    if (errorCount == 0 && i_dut.u_pmaAssert.failCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: bench/pma_assert.sv
`timescale 1ns/1ps
`include "pma_consts.svh"

module pmaAssert (
  input logic                 clock,
  input logic                 rstN,
  input logic                 reqReady,
  input logic                 wbReady,
  input logic                 paValid,
  input logic                 paReady,
  input logic [`PA_WIDTH-1:0] pa,
  input logic                 issue,
  input logic                 ubrLoad,
  input logic                 ebrLoad,
  input logic                 sweepLoad,
  input pmaPkg::seqStateE     state
);

  import pmaPkg::*;

  int failCount = 0;

  readyExclusive: assert property (@(posedge clock) disable iff (!rstN)
    !(reqReady && wbReady))
    else begin
      failCount++;
      $error("reqReady and wbReady are high in the same cycle");
    end

  // a stalled address stays on the output until the consumer takes it.
  outputHeld: assert property (@(posedge clock) disable iff (!rstN)
    (paValid && !paReady) |=> (paValid && $stable(pa)))
    else begin
      failCount++;
      $error("pa or paValid changed while paReady was low");
    end

  resetQuiet: assert property (@(posedge clock) $rose(rstN) |->
    !paValid && !issue && !reqReady && !wbReady && !ubrLoad && !ebrLoad && !sweepLoad &&
    state == stIdle)
    else begin
      failCount++;
      $error("the sequencer was active in the first cycle after reset");
    end

  sweepEntry: assert property (@(posedge clock) disable iff (!rstN)
    $rose(state == stSweep) |-> $past(sweepLoad))
    else begin
      failCount++;
      $error("the sweep state was entered without a sweep load");
    end

endmodule

// File: design/pmaTop.sv
`timescale 1ns/1ps
`include "pma_consts.svh"

module pmaTop (
  input  logic                 clock,
  input  logic                 rstN,
  input  logic                 reqValid,
  output logic                 reqReady,
  input  pmaPkg::reqOpE        reqOp,
  input  logic [`PA_WIDTH-1:0] reqAddr,
  input  logic                 reqUser,
  input  logic                 reqPaged,
  input  logic                 wbValid,
  output logic                 wbReady,
  input  logic [`PA_WIDTH-1:0] wbAddr,
  output logic                 paValid,
  input  logic                 paReady,
  output logic [`PA_WIDTH-1:0] pa,
  output logic                 paPar,
  output pmaPkg::cycleE        paCycle
);

  import pmaPkg::*;

  logic                   slotFree;
  logic                   issue;
  cycleE                  issueCycle;
  logic                   ubrLoad;
  logic                   ebrLoad;
  logic                   sweepLoad;
  logic                   sweepStep;
  logic                   sweepLast;
  logic [`PA_WIDTH-1:0]   sweepAddr;
  logic [`PAGE_WIDTH-1:0] basePage;

  cycleSequencer i_seq (
    .clock(clock), .rstN(rstN),
    .reqValid(reqValid), .reqReady(reqReady), .reqOp(reqOp),
    .wbValid(wbValid), .wbReady(wbReady),
    .slotFree(slotFree), .sweepLast(sweepLast),
    .issue(issue), .issueCycle(issueCycle),
    .ubrLoad(ubrLoad), .ebrLoad(ebrLoad),
    .sweepLoad(sweepLoad), .sweepStep(sweepStep)
  );

  sweepCounter i_sweep (
    .clock(clock), .rstN(rstN),
    .sweepLoad(sweepLoad), .sweepStep(sweepStep), .reqAddr(reqAddr),
    .sweepAddr(sweepAddr), .sweepLast(sweepLast)
  );

  baseRegisters i_base (
    .clock(clock), .rstN(rstN),
    .ubrLoad(ubrLoad), .ebrLoad(ebrLoad),
    .reqAddr(reqAddr), .reqUser(reqUser), .basePage(basePage)
  );

  addressMux i_mux (
    .clock(clock), .rstN(rstN),
    .issue(issue), .issueCycle(issueCycle),
    .reqAddr(reqAddr), .reqPaged(reqPaged), .basePage(basePage),
    .wbAddr(wbAddr), .sweepAddr(sweepAddr),
    .paValid(paValid), .paReady(paReady), .pa(pa), .paPar(paPar),
    .paCycle(paCycle), .slotFree(slotFree)
  );

endmodule

// File: design/addressMux.sv
`timescale 1ns/1ps
`include "pma_consts.svh"

module addressMux (
  input  logic                   clock,
  input  logic                   rstN,
  input  logic                   issue,
  input  pmaPkg::cycleE          issueCycle,
  input  logic [`PA_WIDTH-1:0]   reqAddr,
  input  logic                   reqPaged,
  input  logic [`PAGE_WIDTH-1:0] basePage,
  input  logic [`PA_WIDTH-1:0]   wbAddr,
  input  logic [`PA_WIDTH-1:0]   sweepAddr,
  output logic                   paValid,
  input  logic                   paReady,
  output logic [`PA_WIDTH-1:0]   pa,
  output logic                   paPar,
  output pmaPkg::cycleE          paCycle,
  output logic                   slotFree
);

  import pmaPkg::*;

  logic [`PA_WIDTH-1:0] era;
  logic [`PA_WIDTH-1:0] selAddr;

  always_comb begin
    case (issueCycle)
      cycEbox: begin
        // a paged reference keeps only the line offset of the request.
        if (reqPaged) begin
          selAddr = {basePage, reqAddr[`LINE_WIDTH-1:0]};
        end else begin
          selAddr = reqAddr;
        end
      end
      cycWriteback: selAddr = wbAddr;
      cycSweep:     selAddr = sweepAddr;
      cycEra:       selAddr = era;
      default:      selAddr = reqAddr;
    endcase
  end

  // the output register can take a new address when empty or draining.
  assign slotFree = ~paValid | paReady;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      paValid <= 1'b0;
      era     <= '0;
    end else begin
      if (issue) begin
        paValid <= 1'b1;
      end else if (paReady) begin
        paValid <= 1'b0;
      end
      // replays leave the error address alone so they can repeat.
      if (issue && issueCycle != cycEra) begin
        era <= selAddr;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      pa      <= selAddr;
      paCycle <= issueCycle;
    end
  end

  // odd parity over pa and paPar together.
  assign paPar = ~^pa;

endmodule

// File: design/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer (
  input  logic            clock,
  input  logic            rstN,
  input  logic            reqValid,
  output logic            reqReady,
  input  pmaPkg::reqOpE   reqOp,
  input  logic            wbValid,
  output logic            wbReady,
  input  logic            slotFree,
  input  logic            sweepLast,
  output logic            issue,
  output pmaPkg::cycleE   issueCycle,
  output logic            ubrLoad,
  output logic            ebrLoad,
  output logic            sweepLoad,
  output logic            sweepStep
);

  import pmaPkg::*;

  seqStateE state;
  seqStateE nextState;
  logic     started;

  // started keeps both channels closed for the first cycle out of reset.
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state   <= stIdle;
      started <= 1'b0;
    end else begin
      state   <= nextState;
      started <= 1'b1;
    end
  end

  always_comb begin
    nextState  = state;
    reqReady   = 1'b0;
    wbReady    = 1'b0;
    issue      = 1'b0;
    issueCycle = cycEbox;
    ubrLoad    = 1'b0;
    ebrLoad    = 1'b0;
    sweepLoad  = 1'b0;
    sweepStep  = 1'b0;
    case (state)
      stIdle: begin
        // writebacks win over processor requests.
        wbReady  = started & slotFree & wbValid;
        reqReady = started & slotFree & ~wbValid;
        if (wbValid && wbReady) begin
          issue      = 1'b1;
          issueCycle = cycWriteback;
        end else if (reqValid && reqReady) begin
          case (reqOp)
            opRead: issue = 1'b1;
            opReadEra: begin
              issue      = 1'b1;
              issueCycle = cycEra;
            end
            opLoadUbr: ubrLoad = 1'b1;
            opLoadEbr: ebrLoad = 1'b1;
            opSweep: begin
              sweepLoad = 1'b1;
              nextState = stSweep;
            end
            default: ;
          endcase
        end
      end
      stSweep: begin
        issueCycle = cycSweep;
        if (slotFree) begin
          issue = 1'b1;
          // the line at offset zero ends the sweep.
          if (sweepLast) begin
            nextState = stIdle;
          end else begin
            sweepStep = 1'b1;
          end
        end
      end
      default: nextState = stIdle;
    endcase
  end

endmodule

// File: design/sweepCounter.sv
`timescale 1ns/1ps
`include "pma_consts.svh"

module sweepCounter (
  input  logic                 clock,
  input  logic                 rstN,
  input  logic                 sweepLoad,
  input  logic                 sweepStep,
  input  logic [`PA_WIDTH-1:0] reqAddr,
  output logic [`PA_WIDTH-1:0] sweepAddr,
  output logic                 sweepLast
);

  logic [`PAGE_WIDTH-1:0] sweepPage;
  logic [`LINE_WIDTH-1:0] lineOffset;

  // the swept page comes from the request that starts the sweep.
  always_ff @(posedge clock) begin
    if (sweepLoad) begin
      sweepPage <= reqAddr[`PA_WIDTH-1 -: `PAGE_WIDTH];
    end
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      lineOffset <= '0;
    end else if (sweepLoad) begin
      lineOffset <= `LINE_WIDTH'(`SWEEP_LAST);
    end else if (sweepStep) begin
      lineOffset <= lineOffset - 1'b1;
    end
  end

  assign sweepAddr = {sweepPage, lineOffset};

  // acts as the carry out of the line counter.
  assign sweepLast = (lineOffset == '0);

endmodule

// File: design/baseRegisters.sv
`timescale 1ns/1ps
`include "pma_consts.svh"

module baseRegisters (
  input  logic                   clock,
  input  logic                   rstN,
  input  logic                   ubrLoad,
  input  logic                   ebrLoad,
  input  logic [`PA_WIDTH-1:0]   reqAddr,
  input  logic                   reqUser,
  output logic [`PAGE_WIDTH-1:0] basePage
);

  logic [`PAGE_WIDTH-1:0] ubr;
  logic [`PAGE_WIDTH-1:0] ebr;
  logic [`PAGE_WIDTH-1:0] loadPage;

  // the new base comes from the page field of the request address.
  assign loadPage = reqAddr[`PA_WIDTH-1 -: `PAGE_WIDTH];

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      ubr <= '0;
      ebr <= '0;
    end else begin
      if (ubrLoad) begin
        ubr <= loadPage;
      end
      if (ebrLoad) begin
        ebr <= loadPage;
      end
    end
  end

  // user references page through the UBR, executive ones through the EBR.
  assign basePage = reqUser ? ubr : ebr;

endmodule

// File: design/pmaPkg.sv
package pmaPkg;

  // request opcodes on the processor channel.
  typedef enum logic [2:0] {
    opRead    = 3'd0,
    opLoadUbr = 3'd1,
    opLoadEbr = 3'd2,
    opSweep   = 3'd3,
    opReadEra = 3'd4
  } reqOpE;

  // source of an issued physical address.
  typedef enum logic [2:0] {
    cycEbox      = 3'd0,
    cycWriteback = 3'd1,
    cycSweep     = 3'd2,
    cycEra       = 3'd3
  } cycleE;

  typedef enum logic {
    stIdle  = 1'b0,
    stSweep = 1'b1
  } seqStateE;

endpackage

// File: include/pma_consts.svh
`ifndef PMA_CONSTS_SVH
`define PMA_CONSTS_SVH

// physical and virtual address width.
`define PA_WIDTH 22

// the page field sits above the line offset.
`define PAGE_WIDTH 13
`define LINE_WIDTH 9

// a sweep starts at this line offset and counts down to zero.
`define SWEEP_LAST 7

`endif
